// ==== hdl/lpif_link_pkg.sv ====
// Gen2 full rate on one clock only, with no credit FIFO and a fixed PHY bit order given below
package lpif_link_pkg;

  ////////////////////////////////////////
  // Widths

  // Flit payload carried per PHY word
  localparam int FLIT_W = 141;
  // One PHY lane word per clk_wr cycle
  localparam int PHY_W  = 160;
  // Online delay programming width
  localparam int DLY_W  = 16;
  // Debug counter width
  localparam int CNT_W  = 32;

  ////////////////////////////////////////
  // Control bit positions in the PHY word

  // Strobe sits low so word alignment finds it early
  localparam int STB_POS  = 1;
  // Marker 0 at the top of the lower half
  localparam int MRK0_POS = 79;
  // Marker 1 at the very top of the word
  localparam int MRK1_POS = 159;
  localparam int MRK_W    = 2;

  // Persistent marker pattern once sync starts
  // Marker 1 set, marker 0 clear
  localparam logic [MRK_W-1:0] MRK_AUTO = 2'b10;

  ////////////////////////////////////////
  // Flit layout
  //
  // Payload order in the PHY word
  //   Payload bits fill PHY bits from 0 upward
  //   PHY bits STB_POS, MRK0_POS and MRK1_POS are skipped
  //   Flit bit 0 goes first, so the field order on the wire is
  //     valid, crc_valid, crc, dvalid, data, protid, state
  //   Payload therefore ends at PHY bit 142
  //   Unused PHY bits above the payload are zero, except marker 1

  // First declared field is the MSB, so valid lands at flit bit 0
  typedef struct packed {
    logic [3:0]   state;
    logic [1:0]   protid;
    logic [127:0] data;
    logic         dvalid;
    logic [3:0]   crc;
    logic         crc_valid;
    logic         valid;
  } lpif_flit_t;

  ////////////////////////////////////////
  // Debug status

  // Both counters wrap
  typedef struct packed {
    // Words sent with flit valid while tx online delayed is high
    logic [CNT_W-1:0] tx_sent;
    // Received words dropped for a missing strobe
    logic [CNT_W-1:0] rx_drop;
  } debug_status_t;

endpackage

// ==== hdl/lpif_auto_sync.sv ====
// Delays count clk_wr cycles and saturate at all ones; one low online cycle restarts its chain
`timescale 1ns/1ns

module lpif_auto_sync (
  input  logic                               clk_wr,
  input  logic                               arst_n,

  // Raw online levels from the link controller
  input  logic                               tx_online,
  input  logic                               rx_online,

  // Programmed delays in clk_wr cycles
  input  logic [lpif_link_pkg::DLY_W-1:0]    delay_x_value,
  input  logic [lpif_link_pkg::DLY_W-1:0]    delay_y_value,
  input  logic [lpif_link_pkg::DLY_W-1:0]    delay_z_value,

  // User marker and strobe before sync
  input  logic [lpif_link_pkg::MRK_W-1:0]    tx_mrk_userbit,
  input  logic                               tx_stb_userbit,

  output logic                               tx_online_dly,
  output logic                               rx_online_dly,
  output logic [lpif_link_pkg::MRK_W-1:0]    auto_mrk,
  output logic                               auto_stb
);

  ////////////////////////////////////////
  // Delay stages
  //
  // Stage 0  tx marker start after delay_y
  // Stage 1  tx data start after delay_z once stage 0 is on
  // Stage 2  rx word alignment after delay_x

  logic [2:0]                     st_en;
  logic [2:0]                     st_act;
  logic [lpif_link_pkg::DLY_W-1:0] st_dly [3];

  // Markers gate the data stage
  assign st_en[0]  = tx_online;
  assign st_en[1]  = st_act[0];
  assign st_en[2]  = rx_online;

  assign st_dly[0] = delay_y_value;
  assign st_dly[1] = delay_z_value;
  assign st_dly[2] = delay_x_value;

  for (genvar i = 0; i < 3; i++) begin : g_stage
    logic [lpif_link_pkg::DLY_W-1:0] cnt;
    logic                            on;

    always_ff @(posedge clk_wr or negedge arst_n) begin
      if (!arst_n) begin
        cnt <= '0;
        on  <= 1'b0;
      end else if (!st_en[i]) begin
        // Start over when the enable drops
        cnt <= '0;
        on  <= 1'b0;
      end else begin
        // Saturate instead of wrapping
        if (cnt != '1) begin
          cnt <= cnt + 1'b1;
        end
        // Sticky once the count is reached
        if (cnt >= st_dly[i]) begin
          on <= 1'b1;
        end
      end
    end

    // Live enable masks the flag in the cycle the input falls
    assign st_act[i] = on & st_en[i];
  end

  ////////////////////////////////////////
  // Outputs

  assign tx_online_dly = st_act[1];
  assign rx_online_dly = st_act[2];

  // Persistent marker ORed over the user bits once active
  assign auto_mrk = st_act[0] ? (lpif_link_pkg::MRK_AUTO | tx_mrk_userbit)
                              : tx_mrk_userbit;

  // Strobe forced high once active
  assign auto_stb = st_act[0] | tx_stb_userbit;

endmodule

// ==== hdl/lpif_flit_map.sv ====
// Purely combinational and expects rx_flit and rx_word_ok to be registered upstream
`timescale 1ns/1ns

module lpif_flit_map (
  // Downstream user fields
  input  logic [3:0]                 dstrm_state,
  input  logic [1:0]                 dstrm_protid,
  input  logic [127:0]               dstrm_data,
  input  logic                       dstrm_dvalid,
  input  logic [3:0]                 dstrm_crc,
  input  logic                       dstrm_crc_valid,
  input  logic                       dstrm_valid,

  // Upstream user fields
  output logic [3:0]                 ustrm_state,
  output logic [1:0]                 ustrm_protid,
  output logic [127:0]               ustrm_data,
  output logic                       ustrm_dvalid,
  output logic [3:0]                 ustrm_crc,
  output logic                       ustrm_crc_valid,
  output logic                       ustrm_valid,

  // Flit side toward the PHY concat
  output lpif_link_pkg::lpif_flit_t  dstrm_flit,
  input  lpif_link_pkg::lpif_flit_t  rx_flit,
  input  logic                       rx_word_ok
);

  ////////////////////////////////////////
  // Downstream pack

  assign dstrm_flit.state     = dstrm_state;
  assign dstrm_flit.protid    = dstrm_protid;
  assign dstrm_flit.data      = dstrm_data;
  assign dstrm_flit.dvalid    = dstrm_dvalid;
  assign dstrm_flit.crc       = dstrm_crc;
  assign dstrm_flit.crc_valid = dstrm_crc_valid;
  assign dstrm_flit.valid     = dstrm_valid;

  ////////////////////////////////////////
  // Upstream unpack

  lpif_link_pkg::lpif_flit_t us_flit;

  // Only accepted words reach the user
  // Dropped strobe or rx offline gives all zero
  assign us_flit = rx_word_ok ? rx_flit : '0;

  assign ustrm_state     = us_flit.state;
  assign ustrm_protid    = us_flit.protid;
  assign ustrm_data      = us_flit.data;
  assign ustrm_dvalid    = us_flit.dvalid;
  assign ustrm_crc       = us_flit.crc;
  assign ustrm_crc_valid = us_flit.crc_valid;
  assign ustrm_valid     = us_flit.valid;

endmodule

// ==== hdl/lpif_phy_concat.sv ====
// Transmit word and receive flit each take one register stage, and the debug counters wrap
`timescale 1ns/1ns

module lpif_phy_concat (
  input  logic                                 clk_wr,
  input  logic                                 arst_n,

  // From auto sync
  input  logic                                 tx_online_dly,
  input  logic                                 rx_online_dly,
  input  logic                                 auto_stb,
  input  logic [lpif_link_pkg::MRK_W-1:0]      auto_mrk,

  // Flit side
  input  lpif_link_pkg::lpif_flit_t            dstrm_flit,
  output lpif_link_pkg::lpif_flit_t            rx_flit,
  output logic                                 rx_word_ok,

  // PHY side
  output logic [lpif_link_pkg::PHY_W-1:0]      tx_phy0,
  input  logic [lpif_link_pkg::PHY_W-1:0]      rx_phy0,

  output lpif_link_pkg::debug_status_t         debug
);

  ////////////////////////////////////////
  // Bit order helpers

  // Strobe and marker slots carry no payload
  function automatic logic is_ctrl(input int p);
    return (p == lpif_link_pkg::STB_POS) ||
           (p == lpif_link_pkg::MRK0_POS) ||
           (p == lpif_link_pkg::MRK1_POS);
  endfunction

  // Flit bits into PHY bits from 0 upward
  function automatic logic [lpif_link_pkg::PHY_W-1:0] scatter(
    input logic [lpif_link_pkg::FLIT_W-1:0] f
  );
    logic [lpif_link_pkg::PHY_W-1:0] w;
    int                              k;
    w = '0;
    k = 0;
    for (int p = 0; p < lpif_link_pkg::PHY_W; p++) begin
      if (!is_ctrl(p) && (k < lpif_link_pkg::FLIT_W)) begin
        w[p] = f[k];
        k++;
      end
    end
    return w;
  endfunction

  // Inverse of scatter
  function automatic logic [lpif_link_pkg::FLIT_W-1:0] gather(
    input logic [lpif_link_pkg::PHY_W-1:0] w
  );
    logic [lpif_link_pkg::FLIT_W-1:0] f;
    int                               k;
    f = '0;
    k = 0;
    for (int p = 0; p < lpif_link_pkg::PHY_W; p++) begin
      if (!is_ctrl(p) && (k < lpif_link_pkg::FLIT_W)) begin
        f[k] = w[p];
        k++;
      end
    end
    return f;
  endfunction

  ////////////////////////////////////////
  // Transmit

  lpif_link_pkg::lpif_flit_t        tx_pay;
  logic [lpif_link_pkg::PHY_W-1:0]  tx_word;

  // Payload held at zero until data start
  assign tx_pay = tx_online_dly ? dstrm_flit : '0;

  always_comb begin
    tx_word                          = scatter(tx_pay);
    // Control bits always follow auto sync
    tx_word[lpif_link_pkg::STB_POS]  = auto_stb;
    tx_word[lpif_link_pkg::MRK0_POS] = auto_mrk[0];
    tx_word[lpif_link_pkg::MRK1_POS] = auto_mrk[1];
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= tx_word;
    end
  end

  ////////////////////////////////////////
  // Receive

  logic rx_stb;

  assign rx_stb = rx_phy0[lpif_link_pkg::STB_POS];

  // Received payload is gated by rx_word_ok in the flit map
  always_ff @(posedge clk_wr) begin
    rx_flit <= gather(rx_phy0);
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_word_ok <= 1'b0;
    end else begin
      // Accept only aligned words with strobe present
      rx_word_ok <= rx_online_dly & rx_stb;
    end
  end

  ////////////////////////////////////////
  // Debug counters

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      debug <= '0;
    end else begin
      // Valid flit registered for transmit
      if (tx_online_dly && dstrm_flit.valid) begin
        debug.tx_sent <= debug.tx_sent + 1'b1;
      end
      // Word seen while aligned but strobe missing
      if (rx_online_dly && !rx_stb) begin
        debug.rx_drop <= debug.rx_drop + 1'b1;
      end
    end
  end

endmodule

// ==== hdl/lpif_link_top.sv ====
// Single channel Gen2 master only; dstrm reaches ustrm two cycles later when tx_phy0 loops to rx_phy0
`timescale 1ns/1ns

module lpif_link_top (
  input  logic                                 clk_wr,
  input  logic                                 arst_n,

  // Link control
  input  logic                                 tx_online,
  input  logic                                 rx_online,

  // Sync configuration
  input  logic [lpif_link_pkg::MRK_W-1:0]      tx_mrk_userbit,
  input  logic                                 tx_stb_userbit,
  input  logic [lpif_link_pkg::DLY_W-1:0]      delay_x_value,
  input  logic [lpif_link_pkg::DLY_W-1:0]      delay_y_value,
  input  logic [lpif_link_pkg::DLY_W-1:0]      delay_z_value,

  // Downstream channel
  input  logic [3:0]                           dstrm_state,
  input  logic [1:0]                           dstrm_protid,
  input  logic [127:0]                         dstrm_data,
  input  logic                                 dstrm_dvalid,
  input  logic [3:0]                           dstrm_crc,
  input  logic                                 dstrm_crc_valid,
  input  logic                                 dstrm_valid,

  // Upstream channel
  output logic [3:0]                           ustrm_state,
  output logic [1:0]                           ustrm_protid,
  output logic [127:0]                         ustrm_data,
  output logic                                 ustrm_dvalid,
  output logic [3:0]                           ustrm_crc,
  output logic                                 ustrm_crc_valid,
  output logic                                 ustrm_valid,

  // PHY lane
  output logic [lpif_link_pkg::PHY_W-1:0]      tx_phy0,
  input  logic [lpif_link_pkg::PHY_W-1:0]      rx_phy0,

  // Debug
  output logic [lpif_link_pkg::CNT_W-1:0]      tx_debug_status,
  output logic [lpif_link_pkg::CNT_W-1:0]      rx_debug_status
);

  ////////////////////////////////////////
  // Interconnect

  lpif_link_pkg::lpif_flit_t              dstrm_flit;
  lpif_link_pkg::lpif_flit_t              rx_flit;
  logic                                   rx_word_ok;
  logic                                   tx_online_dly;
  logic                                   rx_online_dly;
  logic [lpif_link_pkg::MRK_W-1:0]        auto_mrk;
  logic                                   auto_stb;
  lpif_link_pkg::debug_status_t           debug;

  assign tx_debug_status = debug.tx_sent;
  assign rx_debug_status = debug.rx_drop;

  ////////////////////////////////////////
  // Auto sync

  lpif_auto_sync u_auto_sync (
    .clk_wr         (clk_wr),
    .arst_n         (arst_n),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .delay_z_value  (delay_z_value),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_stb_userbit (tx_stb_userbit),
    .tx_online_dly  (tx_online_dly),
    .rx_online_dly  (rx_online_dly),
    .auto_mrk       (auto_mrk),
    .auto_stb       (auto_stb)
  );

  ////////////////////////////////////////
  // User field mapping

  lpif_flit_map u_flit_map (
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .dstrm_flit      (dstrm_flit),
    .rx_flit         (rx_flit),
    .rx_word_ok      (rx_word_ok)
  );

  ////////////////////////////////////////
  // PHY word build and decode

  lpif_phy_concat u_phy_concat (
    .clk_wr        (clk_wr),
    .arst_n        (arst_n),
    .tx_online_dly (tx_online_dly),
    .rx_online_dly (rx_online_dly),
    .auto_stb      (auto_stb),
    .auto_mrk      (auto_mrk),
    .dstrm_flit    (dstrm_flit),
    .rx_flit       (rx_flit),
    .rx_word_ok    (rx_word_ok),
    .tx_phy0       (tx_phy0),
    .rx_phy0       (rx_phy0),
    .debug         (debug)
  );

endmodule

// ==== verification/lpif_link_chk.sv ====
// Bound into lpif_link_top; checks are disabled while arst_n is low
`timescale 1ns/1ns

module lpif_link_chk (
  input logic         clk_wr,
  input logic         arst_n,
  input logic         tx_online,
  input logic         rx_online,
  input logic         tx_online_dly,
  input logic         rx_online_dly,
  input logic [159:0] tx_phy0
);

  // Failure count that the testbench reads
  int fails = 0;

  ////////////////////////////////////////
  // Online ordering

  a_tx_dly : assert property (@(posedge clk_wr) disable iff (!arst_n)
    tx_online_dly |-> tx_online)
  else begin
    $error("tx_online_dly high without tx_online");
    fails++;
  end

  a_rx_dly : assert property (@(posedge clk_wr) disable iff (!arst_n)
    rx_online_dly |-> rx_online)
  else begin
    $error("rx_online_dly high without rx_online");
    fails++;
  end

  ////////////////////////////////////////
  // Marker and strobe once data flows

  // Word registered in that cycle carries strobe and the auto marker
  a_mrk_stb : assert property (@(posedge clk_wr) disable iff (!arst_n)
    tx_online_dly |=> tx_phy0[lpif_link_pkg::STB_POS] &&
      (({tx_phy0[lpif_link_pkg::MRK1_POS], tx_phy0[lpif_link_pkg::MRK0_POS]} &
        lpif_link_pkg::MRK_AUTO) == lpif_link_pkg::MRK_AUTO))
  else begin
    $error("tx_phy0 lacks strobe or auto marker while tx online");
    fails++;
  end

endmodule

bind lpif_link_top lpif_link_chk u_chk (
  .clk_wr        (clk_wr),
  .arst_n        (arst_n),
  .tx_online     (tx_online),
  .rx_online     (rx_online),
  .tx_online_dly (tx_online_dly),
  .rx_online_dly (rx_online_dly),
  .tx_phy0       (tx_phy0)
);

// ==== verification/lpif_link_tb.sv ====
// Loopback of tx_phy0 into rx_phy0 only; the model tracks the sync counters and 2 cycle latency
`timescale 1ns/1ns

module lpif_link_tb;

  // Cycle budget of each test as summed by the watchdog
  localparam int CYC_IDLE  = 24;
  localparam int CYC_DLY   = 3 * 50;
  localparam int CYC_BITS  = 45;
  localparam int CYC_LOOP  = 300;
  localparam int CYC_STB   = 200;
  localparam int CYC_SENT  = 100;
  localparam int CYC_TOTAL = CYC_IDLE + CYC_DLY + CYC_BITS + CYC_LOOP + CYC_STB + CYC_SENT;

  logic clk_wr;
  logic arst_n;
  logic tx_online;
  logic rx_online;
  logic [1:0] tx_mrk_userbit;
  logic tx_stb_userbit;
  logic [15:0] delay_x_value;
  logic [15:0] delay_y_value;
  logic [15:0] delay_z_value;
  logic corrupt;
  lpif_link_pkg::lpif_flit_t dflit;
  logic [159:0] tx_phy0;
  logic [159:0] rx_phy0;
  logic [31:0] tx_debug_status;
  logic [31:0] rx_debug_status;
  logic [3:0] us_state;
  logic [1:0] us_protid;
  logic [127:0] us_data;
  logic us_dvalid;
  logic [3:0] us_crc;
  logic us_crc_valid;
  logic us_valid;

  // Next values applied on the following rising edge
  logic nx_tx_on;
  logic nx_rx_on;
  logic [1:0] nx_mrk;
  logic nx_stb;
  logic [15:0] nx_x;
  logic [15:0] nx_y;
  logic [15:0] nx_z;

  // Reference model state
  int unsigned m_tx_cnt;
  int unsigned m_z_cnt;
  int unsigned m_rx_cnt;
  logic [159:0] m_word;
  lpif_link_pkg::lpif_flit_t m_pay;
  lpif_link_pkg::lpif_flit_t m_us;
  lpif_link_pkg::debug_status_t m_dbg;
  int pos_of [lpif_link_pkg::FLIT_W];

  logic [31:0] lfsr;
  int errors;
  int test_errs;
  int tests_run;

  // Strobe can be knocked out on the wire
  assign rx_phy0 = tx_phy0 & ~({{159{1'b0}}, corrupt} << lpif_link_pkg::STB_POS);

  lpif_link_top u_dut (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_stb_userbit  (tx_stb_userbit),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .dstrm_state     (dflit.state),
    .dstrm_protid    (dflit.protid),
    .dstrm_data      (dflit.data),
    .dstrm_dvalid    (dflit.dvalid),
    .dstrm_crc       (dflit.crc),
    .dstrm_crc_valid (dflit.crc_valid),
    .dstrm_valid     (dflit.valid),
    .ustrm_state     (us_state),
    .ustrm_protid    (us_protid),
    .ustrm_data      (us_data),
    .ustrm_dvalid    (us_dvalid),
    .ustrm_crc       (us_crc),
    .ustrm_crc_valid (us_crc_valid),
    .ustrm_valid     (us_valid),
    .tx_phy0         (tx_phy0),
    .rx_phy0         (rx_phy0),
    .tx_debug_status (tx_debug_status),
    .rx_debug_status (rx_debug_status)
  );

  initial begin
    clk_wr = 1'b0;
    forever #10 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////
  // Random source

  // Galois LFSR with taps 32 22 2 1
  function automatic logic lfsr_step();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_step()};
    end
    return r;
  endfunction

  function automatic lpif_link_pkg::lpif_flit_t rand_flit();
    lpif_link_pkg::lpif_flit_t f;
    f.state     = 4'(rand_bits(4));
    f.protid    = 2'(rand_bits(2));
    f.data      = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
    f.dvalid    = 1'(rand_bits(1));
    f.crc       = 4'(rand_bits(4));
    f.crc_valid = 1'(rand_bits(1));
    f.valid     = 1'(rand_bits(1));
    return f;
  endfunction

  ////////////////////////////////////////
  // Reference model

  // Payload slot list that skips strobe and markers
  task automatic build_pos_map();
    int p;
    p = 0;
    for (int k = 0; k < lpif_link_pkg::FLIT_W; k++) begin
      while (p == lpif_link_pkg::STB_POS || p == lpif_link_pkg::MRK0_POS ||
             p == lpif_link_pkg::MRK1_POS) begin
        p++;
      end
      pos_of[k] = p;
      p++;
    end
  endtask

  // One rising edge with the inputs as the DUT samples them
  task automatic model_edge();
    logic mrk_on;
    logic txd_on;
    logic rxd_on;
    logic rx_stb;
    logic [1:0] mrk;
    logic [lpif_link_pkg::FLIT_W-1:0] pay;
    mrk_on = tx_online && (m_tx_cnt > delay_y_value);
    txd_on = mrk_on && (m_z_cnt > delay_z_value);
    rxd_on = rx_online && (m_rx_cnt > delay_x_value);
    // Receive side sees the word currently on the wire
    rx_stb = m_word[lpif_link_pkg::STB_POS] && !corrupt;
    m_us = (rxd_on && rx_stb) ? m_pay : '0;
    if (rxd_on && !rx_stb) begin
      m_dbg.rx_drop = m_dbg.rx_drop + 1;
    end
    if (txd_on && dflit.valid) begin
      m_dbg.tx_sent = m_dbg.tx_sent + 1;
    end
    m_pay = txd_on ? dflit : '0;
    pay = m_pay;
    m_word = '0;
    for (int k = 0; k < lpif_link_pkg::FLIT_W; k++) begin
      m_word[pos_of[k]] = pay[k];
    end
    mrk = mrk_on ? (tx_mrk_userbit | lpif_link_pkg::MRK_AUTO) : tx_mrk_userbit;
    m_word[lpif_link_pkg::STB_POS]  = mrk_on | tx_stb_userbit;
    m_word[lpif_link_pkg::MRK0_POS] = mrk[0];
    m_word[lpif_link_pkg::MRK1_POS] = mrk[1];
    // Consecutive high edges per online chain
    m_tx_cnt = tx_online ? m_tx_cnt + 1 : 0;
    m_z_cnt  = mrk_on ? m_z_cnt + 1 : 0;
    m_rx_cnt = rx_online ? m_rx_cnt + 1 : 0;
  endtask

  ////////////////////////////////////////
  // Compare tasks

  task automatic check_flit(input lpif_link_pkg::lpif_flit_t got,
                            input lpif_link_pkg::lpif_flit_t exp);
    if (got !== exp) begin
      $display("** Error @ %0t: ustrm flit %h, expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input logic [159:0] got, input logic [159:0] exp);
    if (got !== exp) begin
      $display("** Error @ %0t: tx_phy0 %h, expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_debug(input lpif_link_pkg::debug_status_t got,
                             input lpif_link_pkg::debug_status_t exp);
    if (got !== exp) begin
      $display("** Error @ %0t: debug sent/drop %0d/%0d, expected %0d/%0d",
               $time, got.tx_sent, got.rx_drop, exp.tx_sent, exp.rx_drop);
      errors++;
    end
  endtask

  task automatic check_all();
    check_word(tx_phy0, m_word);
    check_flit({us_state, us_protid, us_data, us_dvalid, us_crc, us_crc_valid, us_valid},
               m_us);
    check_debug({tx_debug_status, rx_debug_status}, m_dbg);
  endtask

  // Model the edge, apply next inputs, check at the falling edge
  task automatic run_cycle(input lpif_link_pkg::lpif_flit_t f, input logic cut_stb);
    @(posedge clk_wr);
    model_edge();
    dflit          <= f;
    corrupt        <= cut_stb;
    tx_online      <= nx_tx_on;
    rx_online      <= nx_rx_on;
    tx_mrk_userbit <= nx_mrk;
    tx_stb_userbit <= nx_stb;
    delay_x_value  <= nx_x;
    delay_y_value  <= nx_y;
    delay_z_value  <= nx_z;
    @(negedge clk_wr);
    check_all();
  endtask

  task automatic report_test(input string name);
    $display("test %s done, %0d errors", name, errors - test_errs);
    test_errs = errors;
    tests_run++;
  endtask

  ////////////////////////////////////////
  // Watchdog

  initial begin
    repeat (2 * CYC_TOTAL + 10) @(posedge clk_wr);
    $display("Timeout, the tests did not finish within %0d cycles", 2 * CYC_TOTAL);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////
  // Tests

  initial begin
    lfsr = 32'h6dca3b21;
    errors = 0;
    test_errs = 0;
    tests_run = 0;
    arst_n = 1'b0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    tx_mrk_userbit = '0;
    tx_stb_userbit = 1'b0;
    delay_x_value = '0;
    delay_y_value = '0;
    delay_z_value = '0;
    corrupt = 1'b0;
    dflit = '0;
    {nx_tx_on, nx_rx_on, nx_mrk, nx_stb} = '0;
    {nx_x, nx_y, nx_z} = '0;
    {m_tx_cnt, m_z_cnt, m_rx_cnt} = '0;
    m_word = '0;
    m_pay = '0;
    m_us = '0;
    m_dbg = '0;
    build_pos_map();

    repeat (2) @(posedge clk_wr);
    arst_n <= 1'b1;
    @(negedge clk_wr);
    check_all();

    // User marker and strobe pass straight through while idle
    for (int i = 0; i < CYC_IDLE - 2; i++) begin
      nx_mrk = 2'(rand_bits(2));
      nx_stb = 1'(rand_bits(1));
      run_cycle(rand_flit(), 1'b0);
    end
    report_test("idle");

    // Online delay chains then a drop back to idle
    for (int r = 0; r < 3; r++) begin
      nx_x = 16'(rand_bits(3));
      nx_y = 16'(rand_bits(3));
      nx_z = 16'(rand_bits(3));
      nx_mrk = '0;
      nx_stb = 1'b0;
      run_cycle(rand_flit(), 1'b0);
      nx_tx_on = 1'b1;
      nx_rx_on = 1'b1;
      for (int i = 0; i < 39; i++) begin
        run_cycle(rand_flit(), 1'b0);
      end
      nx_tx_on = 1'b0;
      nx_rx_on = 1'b0;
      for (int i = 0; i < 10; i++) begin
        run_cycle(rand_flit(), 1'b0);
      end
    end
    report_test("delays");

    // Zero delays from here on
    nx_x = '0;
    nx_y = '0;
    nx_z = '0;
    nx_tx_on = 1'b1;
    nx_rx_on = 1'b1;
    for (int i = 0; i < CYC_BITS; i++) begin
      nx_mrk = 2'(rand_bits(2));
      run_cycle(rand_flit(), 1'b0);
    end
    report_test("layout");

    for (int i = 0; i < CYC_LOOP; i++) begin
      run_cycle(rand_flit(), 1'b0);
    end
    report_test("loopback");

    // About one word in four loses its strobe
    for (int i = 0; i < CYC_STB; i++) begin
      run_cycle(rand_flit(), 2'(rand_bits(2)) == 2'b11);
    end
    report_test("strobe");

    for (int i = 0; i < CYC_SENT; i++) begin
      run_cycle(rand_flit(), 1'b0);
    end
    check_debug({tx_debug_status, rx_debug_status}, m_dbg);
    report_test("sent");

    errors = errors + u_dut.u_chk.fails;
    $display("%0d tests, %0d errors, %0d assertion failures",
             tests_run, errors, u_dut.u_chk.fails);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
hdl/lpif_link_pkg.sv
hdl/lpif_auto_sync.sv
hdl/lpif_flit_map.sv
hdl/lpif_phy_concat.sv
hdl/lpif_link_top.sv
verification/lpif_link_chk.sv
verification/lpif_link_tb.sv

// ==== Bender.yml ====
package:
  name: lpif_link

sources:
  - hdl/lpif_link_pkg.sv
  - hdl/lpif_auto_sync.sv
  - hdl/lpif_flit_map.sv
  - hdl/lpif_phy_concat.sv
  - hdl/lpif_link_top.sv
  - target: test
    files:
      - verification/lpif_link_chk.sv
      - verification/lpif_link_tb.sv
